/* cycle_counter.sv */
`timescale 1ns/1ps

module cycle_counter (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  perip_pkg::word_t load_value,
    output perip_pkg::word_t rdata
);
    import perip_pkg::*;

    word_t count;

    // Counts every cycle unless software loads it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Read value is the count held just before the sampling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= count;
        end
    end

endmodule

/* dtcm_ram.sv */
`timescale 1ns/1ps

module dtcm_ram (
    input  logic                   clk,
    input  logic                   we,
    input  perip_pkg::byte_mask_t  mask,
    input  perip_pkg::dtcm_index_t waddr,
    input  perip_pkg::word_t       wdata,
    input  perip_pkg::dtcm_index_t raddr,
    output perip_pkg::word_t       rdata
);
    import perip_pkg::*;

    localparam int DEPTH = 2 ** $bits(dtcm_index_t);
    localparam int LANES = $bits(byte_mask_t);

    word_t mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    // Only lanes with their mask bit set are touched
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < LANES; b++) begin
                if (mask[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Read-first, a collision with the write port sees the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* mmio_regs.sv */
`timescale 1ns/1ps
`include "perip_config.svh"

module mmio_regs (
    input  logic             clk,
    input  logic             rst,
    input  logic             led_wen,
    input  logic             seg_wen,
    input  perip_pkg::word_t wdata,
    input  perip_pkg::word_t raddr,
    input  logic [63:0]      sw,
    input  logic [7:0]       key,
    output perip_pkg::word_t led,
    output perip_pkg::word_t seg_value,
    output perip_pkg::word_t rdata
);
    import perip_pkg::*;

    localparam mmio_offset_t SW0_OFF = mmio_offset_t'(`SW0_ADDR - `MMIO_BASE_ADDR);
    localparam mmio_offset_t SW1_OFF = mmio_offset_t'(`SW1_ADDR - `MMIO_BASE_ADDR);
    localparam mmio_offset_t KEY_OFF = mmio_offset_t'(`KEY_ADDR - `MMIO_BASE_ADDR);
    localparam mmio_offset_t SEG_OFF = mmio_offset_t'(`SEG_ADDR - `MMIO_BASE_ADDR);

    mmio_offset_t roffset;
    word_t        rdata_next;

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    // Full word stores, the byte mask plays no part here
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led       <= '0;
            seg_value <= '0;
        end else begin
            if (led_wen) begin
                led <= wdata;
            end
            if (seg_wen) begin
                seg_value <= wdata;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    assign roffset = raddr[`MMIO_OFFSET_WIDTH-1:0];

    always_comb begin
        case (roffset)
            SW0_OFF: rdata_next = sw[31:0];
            SW1_OFF: rdata_next = sw[63:32];
            KEY_OFF: rdata_next = word_t'(key);
            SEG_OFF: rdata_next = seg_value;
            default: rdata_next = `UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else begin
            rdata <= rdata_next;
        end
    end

endmodule

/* perip_bridge.sv */
`timescale 1ns/1ps
`include "perip_config.svh"

module perip_bridge (
    input  logic                clk,
    input  logic                rst,
    input  perip_pkg::wr_req_t  perip_wr,
    input  perip_pkg::word_t    perip_raddr,
    output perip_pkg::word_t    perip_rdata,
    input  logic [63:0]         virtual_sw_input,
    input  logic [7:0]          virtual_key_input,
    output perip_pkg::word_t    virtual_led_output,
    output perip_pkg::seg_out_t virtual_seg_output
);
    import perip_pkg::*;

    localparam word_t DTCM_START = `DTCM_BASE_ADDR;
    localparam word_t DTCM_END   = `DTCM_BASE_ADDR + `DTCM_SIZE;
    localparam word_t MMIO_BASE  = `MMIO_BASE_ADDR;
    localparam int    OFF_W      = `MMIO_OFFSET_WIDTH;

    // Offset that no MMIO register answers
    localparam mmio_offset_t MMIO_HOLE = '1;

    logic        led_wen;
    logic        seg_wen;
    logic        dtcm_wen;
    logic        cnt_wen;
    dtcm_index_t dtcm_waddr;
    dtcm_index_t dtcm_raddr;
    logic        rd_dtcm_hit;
    logic        rd_mmio_hit;
    word_t       mmio_raddr;
    region_t     rd_region;
    region_t     rd_region_q;
    word_t       mmio_rdata;
    word_t       dtcm_rdata;
    word_t       cnt_rdata;
    word_t       seg_value;

    //////////////////////////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////////////////////////

    assign led_wen  = perip_wr.en && (perip_wr.addr == `LED_ADDR);
    assign seg_wen  = perip_wr.en && (perip_wr.addr == `SEG_ADDR);
    assign cnt_wen  = perip_wr.en && (perip_wr.addr == `CNT_ADDR);
    assign dtcm_wen = perip_wr.en && (perip_wr.addr >= DTCM_START)
                      && (perip_wr.addr < DTCM_END);

    // Byte address to word index
    assign dtcm_waddr = perip_wr.addr[`DTCM_ADDR_WIDTH+1:2];

    //////////////////////////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////////////////////////

    assign rd_dtcm_hit = (perip_raddr >= DTCM_START) && (perip_raddr < DTCM_END);
    assign rd_mmio_hit = perip_raddr[31:OFF_W] == MMIO_BASE[31:OFF_W];
    assign dtcm_raddr  = perip_raddr[`DTCM_ADDR_WIDTH+1:2];

    // MMIO block answers everything else, stray addresses land on the hole
    assign mmio_raddr = rd_mmio_hit ? perip_raddr : {perip_raddr[31:OFF_W], MMIO_HOLE};

    always_comb begin
        if (rd_dtcm_hit) begin
            rd_region = REG_DTCM;
        end else if (perip_raddr == `CNT_ADDR) begin
            rd_region = REG_CNT;
        end else begin
            rd_region = REG_MMIO;
        end
    end

    // Region travels alongside the data registered in each block
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_region_q <= REG_NONE;
        end else begin
            rd_region_q <= rd_region;
        end
    end

    always_comb begin
        case (rd_region_q)
            REG_MMIO: perip_rdata = mmio_rdata;
            REG_DTCM: perip_rdata = dtcm_rdata;
            REG_CNT:  perip_rdata = cnt_rdata;
            default:  perip_rdata = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    mmio_regs i_mmio_regs (
        .clk       (clk),
        .rst       (rst),
        .led_wen   (led_wen),
        .seg_wen   (seg_wen),
        .wdata     (perip_wr.data),
        .raddr     (mmio_raddr),
        .sw        (virtual_sw_input),
        .key       (virtual_key_input),
        .led       (virtual_led_output),
        .seg_value (seg_value),
        .rdata     (mmio_rdata)
    );

    dtcm_ram i_dtcm_ram (
        .clk   (clk),
        .we    (dtcm_wen),
        .mask  (perip_wr.mask),
        .waddr (dtcm_waddr),
        .wdata (perip_wr.data),
        .raddr (dtcm_raddr),
        .rdata (dtcm_rdata)
    );

    cycle_counter i_cycle_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (cnt_wen),
        .load_value (perip_wr.data),
        .rdata      (cnt_rdata)
    );

    seg_display i_seg_display (
        .clk     (clk),
        .rst     (rst),
        .value   (seg_value),
        .seg_out (virtual_seg_output)
    );

endmodule

/* perip_config.svh */
`ifndef PERIP_CONFIG_SVH
`define PERIP_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Data TCM window
//////////////////////////////////////////////////////////////////////

`define DTCM_BASE_ADDR      32'h8010_0000

// Word address bits, 4096 words
`define DTCM_ADDR_WIDTH     12

// Size in bytes
`define DTCM_SIZE           ((1 << `DTCM_ADDR_WIDTH) * 4)

//////////////////////////////////////////////////////////////////////
// MMIO window
//////////////////////////////////////////////////////////////////////

`define MMIO_BASE_ADDR      32'h8020_0000

// Low address bits that select a register inside the window
`define MMIO_OFFSET_WIDTH   8

`define SW0_ADDR            (`MMIO_BASE_ADDR + 32'h0000_0000)
`define SW1_ADDR            (`MMIO_BASE_ADDR + 32'h0000_0004)
`define KEY_ADDR            (`MMIO_BASE_ADDR + 32'h0000_0010)
`define SEG_ADDR            (`MMIO_BASE_ADDR + 32'h0000_0020)
`define LED_ADDR            (`MMIO_BASE_ADDR + 32'h0000_0040)
`define CNT_ADDR            (`MMIO_BASE_ADDR + 32'h0000_0050)

// Returned for any address nobody answers
`define UNMAPPED_DATA       32'hDEAD_BEEF

//////////////////////////////////////////////////////////////////////
// Display scan
//////////////////////////////////////////////////////////////////////

// Cycles per digit phase
`define SEG_SCAN_CYCLES     16

`endif

/* perip_pkg.sv */
`include "perip_config.svh"

package perip_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////////////////////////

    // Data or address word
    typedef logic [31:0] word_t;

    // One enable per byte lane
    typedef logic [3:0] byte_mask_t;

    // Word index into the DTCM
    typedef logic [`DTCM_ADDR_WIDTH-1:0] dtcm_index_t;

    // Register offset inside the MMIO window
    typedef logic [`MMIO_OFFSET_WIDTH-1:0] mmio_offset_t;

    // Source of a read in flight
    typedef enum logic [1:0] {
        REG_NONE,
        REG_MMIO,
        REG_DTCM,
        REG_CNT
    } region_t;

    typedef struct packed {
        word_t      addr;
        word_t      data;
        byte_mask_t mask;
        logic       en;
    } wr_req_t;

    //////////////////////////////////////////////////////////////////////
    // Display types
    //////////////////////////////////////////////////////////////////////

    localparam int SEG_GROUPS = 4;

    typedef logic [3:0] nibble_t;

    // ans is one-hot, segments active high
    typedef struct packed {
        logic [1:0] ans;
        logic       dp;
        logic [6:0] seg;
    } seg_group_t;

    // Group 0 sits in the low bits
    typedef seg_group_t [SEG_GROUPS-1:0] seg_out_t;

endpackage

/* project.f */
+incdir+.
perip_pkg.sv
dtcm_ram.sv
cycle_counter.sv
mmio_regs.sv
seg_display.sv
perip_bridge.sv
tb_perip_bridge.sv

/* seg_display.sv */
`timescale 1ns/1ps
`include "perip_config.svh"

module seg_display (
    input  logic                clk,
    input  logic                rst,
    input  perip_pkg::word_t    value,
    output perip_pkg::seg_out_t seg_out
);
    import perip_pkg::*;

    localparam int SCAN_W = $clog2(`SEG_SCAN_CYCLES);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`SEG_SCAN_CYCLES - 1);

    // Segment order is {g, f, e, d, c, b, a}, active high
    function automatic logic [6:0] hex_font(input nibble_t n);
        logic [6:0] pattern;
        case (n)
            4'h0: pattern = 7'h3F;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5B;
            4'h3: pattern = 7'h4F;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6D;
            4'h6: pattern = 7'h7D;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7F;
            4'h9: pattern = 7'h6F;
            4'hA: pattern = 7'h77;
            4'hB: pattern = 7'h7C;
            4'hC: pattern = 7'h39;
            4'hD: pattern = 7'h5E;
            4'hE: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
        return pattern;
    endfunction

    // Digit 0 of a cleared register
    localparam seg_group_t IDLE_GROUP = '{ans: 2'b01, dp: 1'b0, seg: hex_font(4'h0)};

    logic [SCAN_W-1:0] scan_cnt;
    logic              phase;
    seg_out_t          seg_next;

    //////////////////////////////////////////////////////////////////////
    // Scan timing
    //////////////////////////////////////////////////////////////////////

    // phase 0 lights the low digit of each group, phase 1 the high one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            phase    <= 1'b0;
        end else if (scan_cnt == SCAN_LAST) begin
            scan_cnt <= '0;
            phase    <= ~phase;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Digit select and font
    //////////////////////////////////////////////////////////////////////

    // Group g shows nibble 2g or 2g+1
    always_comb begin
        for (int g = 0; g < SEG_GROUPS; g++) begin
            seg_next[g].ans = phase ? 2'b10 : 2'b01;
            seg_next[g].dp  = 1'b0;
            seg_next[g].seg = hex_font(value[(2*g + int'(phase))*4 +: 4]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seg_out <= '{default: IDLE_GROUP};
        end else begin
            seg_out <= seg_next;
        end
    end

endmodule

/* tb_perip_bridge.sv */
`timescale 1ns/1ps
`include "perip_config.svh"

module tb_perip_bridge;
    import perip_pkg::*;

    localparam int         RESET_CYCLES = 8;
    localparam int         DTCM_OPS     = 300;
    localparam int         MMIO_ROUNDS  = 12;
    localparam int         SCAN_CHECK   = 6 * `SEG_SCAN_CYCLES;
    localparam logic[31:0] SEED         = 32'ha7e8ab18;
    localparam word_t      DTCM_END     = `DTCM_BASE_ADDR + `DTCM_SIZE;
    localparam wr_req_t    NO_WR        = '0;

    // Cycles per test, in test order
    localparam int BUDGET = RESET_CYCLES + 4 + (32 + DTCM_OPS + 20) + 30
                            + (MMIO_ROUNDS * 6 + 4) + 60 + (SCAN_CHECK + 8);
    localparam int WATCHDOG_CYCLES = BUDGET + 100;

    // Standard hex font, {g, f, e, d, c, b, a}, entry 0 in the low bits
    localparam logic [15:0][6:0] FONT = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77,
        7'h6F, 7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    logic        clk;
    logic        rst;
    wr_req_t     perip_wr;
    word_t       perip_raddr;
    word_t       perip_rdata;
    logic [63:0] sw_in;
    logic [7:0]  key_in;
    word_t       led_out;
    seg_out_t    seg_out;

    // Shadow state, updated at the same edges as the DUT
    word_t       shadow_dtcm [2 ** `DTCM_ADDR_WIDTH];
    word_t       shadow_seg;
    word_t       shadow_cnt;

    logic [31:0] lfsr;
    word_t       rd_exp;
    logic        rd_chk;
    word_t       pend_exp;
    logic        pend_chk;
    int          checks;
    int          errors;

    perip_bridge i_dut (
        .clk                (clk),
        .rst                (rst),
        .perip_wr           (perip_wr),
        .perip_raddr        (perip_raddr),
        .perip_rdata        (perip_rdata),
        .virtual_sw_input   (sw_in),
        .virtual_key_input  (key_in),
        .virtual_led_output (led_out),
        .virtual_seg_output (seg_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic wr_req_t make_wr(input word_t addr, input word_t data,
                                        input byte_mask_t mask);
        wr_req_t w;
        w.addr = addr;
        w.data = data;
        w.mask = mask;
        w.en   = 1'b1;
        return w;
    endfunction

    // Two 16-word windows, one at each end of the DTCM
    function automatic word_t dtcm_addr(input logic [4:0] slot);
        return `DTCM_BASE_ADDR + {18'b0, slot[4] ? 8'hFF : 8'h00, slot[3:0], 2'b00};
    endfunction

    // Expected read data for an address sampled at the coming edge
    function automatic word_t expected_read(input word_t addr);
        word_t exp;
        if (addr >= `DTCM_BASE_ADDR && addr < DTCM_END) begin
            exp = shadow_dtcm[addr[`DTCM_ADDR_WIDTH+1:2]];
        end else if (addr == `SW0_ADDR) begin
            exp = sw_in[31:0];
        end else if (addr == `SW1_ADDR) begin
            exp = sw_in[63:32];
        end else if (addr == `KEY_ADDR) begin
            exp = {24'h0, key_in};
        end else if (addr == `SEG_ADDR) begin
            exp = shadow_seg;
        end else if (addr == `CNT_ADDR) begin
            exp = shadow_cnt;
        end else begin
            exp = `UNMAPPED_DATA;
        end
        return exp;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic bus_cycle(input wr_req_t wr, input word_t raddr, input logic chk);
        @(negedge clk);
        perip_wr    = wr;
        perip_raddr = raddr;
        rd_exp      = expected_read(raddr);
        rd_chk      = chk;
    endtask

    task automatic idle(input int n);
        repeat (n) bus_cycle(NO_WR, '0, 1'b0);
    endtask

    task automatic end_test(input string name, input int err_before);
        idle(2);
        if (errors == err_before) begin
            $display("test %-12s ok", name);
        end else begin
            $display("test %-12s failed with %0d errors", name, errors - err_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Shadow model and read compare
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            shadow_seg <= '0;
            shadow_cnt <= '0;
        end else begin
            shadow_cnt <= shadow_cnt + 32'd1;
            if (perip_wr.en) begin
                if (perip_wr.addr == `SEG_ADDR) begin
                    shadow_seg <= perip_wr.data;
                end
                if (perip_wr.addr == `CNT_ADDR) begin
                    shadow_cnt <= perip_wr.data;
                end
                if (perip_wr.addr >= `DTCM_BASE_ADDR && perip_wr.addr < DTCM_END) begin
                    for (int b = 0; b < 4; b++) begin
                        if (perip_wr.mask[b]) begin
                            shadow_dtcm[perip_wr.addr[`DTCM_ADDR_WIDTH+1:2]][8*b +: 8]
                                <= perip_wr.data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // One cycle of read latency
    always @(posedge clk) begin
        pend_exp <= rd_exp;
        pend_chk <= rd_chk;
    end

    always @(negedge clk) begin
        if (pend_chk) begin
            check_value("perip_rdata", perip_rdata, pend_exp);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        int         err0;
        int         m;
        int         n;
        int         run;
        int         transitions;
        word_t      data;
        word_t      addr;
        word_t      first;
        word_t      second;
        byte_mask_t mask;
        logic [1:0] prev_ans;

        rst         = 1'b1;
        perip_wr    = NO_WR;
        perip_raddr = '0;
        sw_in       = '0;
        key_in      = '0;
        rd_exp      = '0;
        rd_chk      = 1'b0;
        lfsr        = SEED;
        checks      = 0;
        errors      = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Reset values
        err0 = errors;
        check_value("perip_rdata", perip_rdata, '0);
        check_value("virtual_led_output", led_out, '0);
        for (int g = 0; g < SEG_GROUPS; g++) begin
            check_value($sformatf("virtual_seg_output[%0d]", g), word_t'(seg_out[g]),
                        word_t'({2'b01, 1'b0, FONT[0]}));
        end
        end_test("reset", err0);

        // DTCM fill, then random masked writes under back-to-back reads
        err0 = errors;
        for (int i = 0; i < 32; i++) begin
            data = rand_bits(32);
            bus_cycle(make_wr(dtcm_addr(5'(i)), data, 4'hF), '0, 1'b0);
        end
        for (int i = 0; i < DTCM_OPS; i++) begin
            data = rand_bits(32);
            mask = byte_mask_t'(rand_bits(4));
            addr = dtcm_addr(5'(rand_bits(5)));
            if (rand_bits(2) == 32'd0) begin
                bus_cycle(NO_WR, addr | rand_bits(2), 1'b1);
            end else begin
                bus_cycle(make_wr(dtcm_addr(5'(rand_bits(5))), data, mask),
                          addr | rand_bits(2), 1'b1);
            end
        end
        // Same word on both ports, old data first
        for (int i = 0; i < 8; i++) begin
            data = rand_bits(32);
            mask = byte_mask_t'(rand_bits(4));
            addr = dtcm_addr(5'(rand_bits(5)));
            bus_cycle(make_wr(addr, data, mask), addr, 1'b1);
            bus_cycle(NO_WR, addr, 1'b1);
        end
        end_test("dtcm", err0);

        // LED and SEG store whole words whatever the mask
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            data = rand_bits(32);
            mask = (i == 0) ? 4'h0 : byte_mask_t'(rand_bits(4));
            bus_cycle(make_wr(`LED_ADDR, data, mask), '0, 1'b0);
            bus_cycle(make_wr(`SEG_ADDR, ~data, mask), `SEG_ADDR, 1'b1);
            bus_cycle(NO_WR, `SEG_ADDR, 1'b1);
            check_value("virtual_led_output", led_out, data);
        end
        end_test("led_seg", err0);

        // Switches, keys and stray addresses
        err0 = errors;
        for (int i = 0; i < MMIO_ROUNDS; i++) begin
            idle(1);
            sw_in[31:0]  = rand_bits(32);
            sw_in[63:32] = rand_bits(32);
            key_in       = 8'(rand_bits(8));
            bus_cycle(NO_WR, `SW0_ADDR, 1'b1);
            bus_cycle(NO_WR, `SW1_ADDR, 1'b1);
            bus_cycle(NO_WR, `KEY_ADDR, 1'b1);
            if (rand_bits(1) == 32'd1) begin
                addr = rand_bits(32);
            end else begin
                addr = `MMIO_BASE_ADDR + rand_bits(8);
            end
            bus_cycle(NO_WR, addr, 1'b1);
            bus_cycle(NO_WR, rand_bits(32), 1'b1);
        end
        end_test("inputs", err0);

        // Counter load, then two reads n cycles apart
        err0 = errors;
        for (int k = 0; k < 3; k++) begin
            m    = 1 + k;
            n    = 2 + 5 * k;
            data = rand_bits(32);
            bus_cycle(make_wr(`CNT_ADDR, data, 4'hF), '0, 1'b0);
            idle(m - 1);
            bus_cycle(NO_WR, `CNT_ADDR, 1'b1);
            idle(1);
            first = perip_rdata;
            idle(n - 2);
            bus_cycle(NO_WR, `CNT_ADDR, 1'b1);
            idle(1);
            second = perip_rdata;
            check_value("perip_rdata count", first, data + word_t'(m - 1));
            check_value("perip_rdata delta", second - first, word_t'(n));
        end
        end_test("counter", err0);

        // Display scan over several phases
        err0 = errors;
        data = rand_bits(32);
        bus_cycle(make_wr(`SEG_ADDR, data, 4'h0), '0, 1'b0);
        idle(2);
        prev_ans    = seg_out[0].ans;
        run         = 0;
        transitions = 0;
        for (int c = 0; c < SCAN_CHECK; c++) begin
            idle(1);
            for (int g = 0; g < SEG_GROUPS; g++) begin
                if (seg_out[g].ans == 2'b01) begin
                    check_value($sformatf("virtual_seg_output[%0d].seg", g),
                                word_t'(seg_out[g].seg), word_t'(FONT[data[8*g +: 4]]));
                end else if (seg_out[g].ans == 2'b10) begin
                    check_value($sformatf("virtual_seg_output[%0d].seg", g),
                                word_t'(seg_out[g].seg), word_t'(FONT[data[8*g+4 +: 4]]));
                end else begin
                    errors++;
                    $display("Display group %0d selects no single digit", g);
                end
                check_value($sformatf("virtual_seg_output[%0d].dp", g),
                            word_t'(seg_out[g].dp), '0);
            end
            // Every complete phase lasts one scan period
            if (seg_out[0].ans != prev_ans) begin
                if (transitions > 0 && run != `SEG_SCAN_CYCLES) begin
                    errors++;
                    $display("Display phase lasted %0d cycles instead of %0d",
                             run, `SEG_SCAN_CYCLES);
                end
                transitions++;
                run = 1;
            end else begin
                run++;
            end
            prev_ans = seg_out[0].ans;
        end
        if (transitions < 2) begin
            errors++;
            $display("Display digit select did not alternate");
        end
        end_test("display", err0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
